/* design/idct_defines.svh */
// IDCT engine constants
`ifndef IDCT_DEFINES_SVH
`define IDCT_DEFINES_SVH

// SRAM geometry
`define SRAM_ADDR_W 18

// coefficient region, one 16-bit signed value per word
`define COEF_BASE 76800
`define COEF_STRIDE 320

// pixel region, two pixels per word
`define PIX_STRIDE 160

// block geometry
`define BLOCK_N 8
`define BLOCK_COLS 40
`define BLOCK_ROWS 30

// fixed point, cosine table is scaled by 2^12
`define C_SCALE_BITS 12
`define PASS1_SHIFT 8
`define PASS2_SHIFT 16

`endif

/* design/idct_pkg.sv */
// IDCT shared types
`include "idct_defines.svh"

package idct_pkg;

	typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;
	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] tval_t;
	typedef logic [7:0] pixel_t;
	typedef logic [5:0] ram_addr_t;
	typedef logic [5:0] blk_col_t;
	typedef logic [4:0] blk_row_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		sram_addr_t adr;
		sram_data_t dat_w;
	} wb_m2s_t;

	typedef struct packed {
		logic ack;
		sram_data_t dat_r;
	} wb_s2m_t;

	typedef struct packed {
		logic valid;
		pixel_t pixel;
	} pix_stream_t;

	typedef enum logic [1:0] {F_IDLE, F_READ, F_GAP, F_WAIT} fetch_state_t;
	typedef enum logic [1:0] {E_IDLE, E_PASS1, E_PASS2} engine_state_t;
	typedef enum logic {W_COLLECT, W_WRITE} writer_state_t;

	// C[u][x] at index {u, x}
	localparam logic signed [15:0] c_table [64] = '{
		16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448,
		16'sd2009, 16'sd1703, 16'sd1138, 16'sd400, -16'sd400, -16'sd1138, -16'sd1703, -16'sd2009,
		16'sd1892, 16'sd784, -16'sd784, -16'sd1892, -16'sd1892, -16'sd784, 16'sd784, 16'sd1892,
		16'sd1703, -16'sd400, -16'sd2009, -16'sd1138, 16'sd1138, 16'sd2009, 16'sd400, -16'sd1703,
		16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448, 16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448,
		16'sd1138, -16'sd2009, 16'sd400, 16'sd1703, -16'sd1703, -16'sd400, 16'sd2009, -16'sd1138,
		16'sd784, -16'sd1892, 16'sd1892, -16'sd784, -16'sd784, 16'sd1892, -16'sd1892, 16'sd784,
		16'sd400, -16'sd1138, 16'sd1703, -16'sd2009, 16'sd2009, -16'sd1703, 16'sd1138, -16'sd400
	};

endpackage

/* design/block_ram.sv */
// Dual-port block RAM
module block_ram #(
	parameter int DATA_W = 16
) (
	input  logic                Clock,
	input  idct_pkg::ram_addr_t addr_a_i,
	input  idct_pkg::ram_addr_t addr_b_i,
	input  logic [DATA_W-1:0]   wdata_a_i,
	input  logic [DATA_W-1:0]   wdata_b_i,
	input  logic                we_a_i,
	input  logic                we_b_i,
	output logic [DATA_W-1:0]   rdata_a_o,
	output logic [DATA_W-1:0]   rdata_b_o
);

	logic [DATA_W-1:0] mem [64];

	// reads return the old word on a same-cycle write
	always_ff @(posedge Clock) begin
		if (we_a_i) begin
			mem[addr_a_i] <= wdata_a_i;
		end
		if (we_b_i) begin
			mem[addr_b_i] <= wdata_b_i;
		end
		rdata_a_o <= mem[addr_a_i];
		rdata_b_o <= mem[addr_b_i];
	end

endmodule

/* design/block_fetch.sv */
// Coefficient block fetch
`include "idct_defines.svh"

module block_fetch (
	input  logic                Clock,
	input  logic                Resetn,
	input  logic                start_i,
	input  idct_pkg::blk_col_t  blk_col_i,
	input  idct_pkg::blk_row_t  blk_row_i,
	input  logic                block_done_i,
	output idct_pkg::wb_m2s_t   wb_o,
	input  idct_pkg::wb_s2m_t   wb_i,
	output idct_pkg::ram_addr_t ram_addr_o,
	output idct_pkg::coef_t     ram_data_o,
	output logic                ram_we_o,
	output logic                fetch_done_o,
	output logic                busy_o
);
	import idct_pkg::*;

	fetch_state_t state_q;
	ram_addr_t idx_q;
	logic fetch_done_q;
	logic acked;
	sram_addr_t row_w;
	sram_addr_t col_w;

	// {blk, r} is blk*8 + r
	assign row_w = sram_addr_t'({blk_row_i, idx_q[5:3]});
	assign col_w = sram_addr_t'({blk_col_i, idx_q[2:0]});

	always_comb begin
		wb_o.cyc = (state_q == F_READ) || (state_q == F_GAP);
		wb_o.stb = (state_q == F_READ);
		wb_o.we = 1'b0;
		wb_o.adr = sram_addr_t'(`COEF_BASE) + row_w * sram_addr_t'(`COEF_STRIDE) + col_w;
		wb_o.dat_w = '0;
	end

	assign acked = (state_q == F_READ) && wb_i.ack;

	// each acked word goes straight into the RAM
	assign ram_we_o = acked;
	assign ram_addr_o = idx_q;
	assign ram_data_o = coef_t'(wb_i.dat_r);

	assign busy_o = (state_q != F_IDLE) && !block_done_i;
	assign fetch_done_o = fetch_done_q;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state_q <= F_IDLE;
			idx_q <= '0;
			fetch_done_q <= 1'b0;
		end else begin
			fetch_done_q <= acked && (idx_q == 6'd63);
			case (state_q)
				F_IDLE: begin
					if (start_i) begin
						idx_q <= '0;
						state_q <= F_READ;
					end
				end
				F_READ: begin
					if (wb_i.ack) begin
						idx_q <= idx_q + 6'd1;
						state_q <= (idx_q == 6'd63) ? F_WAIT : F_GAP;
					end
				end
				F_GAP: begin
					state_q <= F_READ;
				end
				F_WAIT: begin
					// a new start may come in the cycle busy drops
					if (block_done_i) begin
						idx_q <= '0;
						state_q <= start_i ? F_READ : F_IDLE;
					end
				end
				default: state_q <= F_IDLE;
			endcase
		end
	end

endmodule

/* design/idct_matrix_engine.sv */
// Two-pass IDCT matrix engine
`include "idct_defines.svh"

module idct_matrix_engine (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  start_i,
	output idct_pkg::ram_addr_t   coef_addr_a_o,
	output idct_pkg::ram_addr_t   coef_addr_b_o,
	input  idct_pkg::coef_t       coef_data_a_i,
	input  idct_pkg::coef_t       coef_data_b_i,
	output idct_pkg::pix_stream_t pix_o,
	input  logic                  pix_ready_i
);
	import idct_pkg::*;

	engine_state_t state_q;
	logic [2:0] ph_q;
	logic [2:0] r_q;
	logic [2:0] c_q;
	logic [2:0] k_issue;
	logic [2:0] k_data;
	logic pass1;
	logic last_ph;
	logic can_load;
	logic advance;
	logic load_out;
	ram_addr_t t_addr_a;
	ram_addr_t t_addr_b;
	ram_addr_t cidx_a;
	ram_addr_t cidx_b;
	tval_t t_rdata_a;
	tval_t t_rdata_b;
	tval_t op_a;
	tval_t op_b;
	tval_t prod_sum;
	tval_t result;
	tval_t scaled;
	tval_t acc_q;
	pixel_t clip_pix;
	logic pix_valid_q;
	pixel_t pix_data_q;

	// ph 0..3 issue k = 0,2,4,6; ph 1..4 see the data one cycle later
	assign k_issue = (ph_q == 3'd4) ? 3'd6 : {ph_q[1:0], 1'b0};
	assign k_data = {ph_q[1:0] - 2'd1, 1'b0};
	assign pass1 = (state_q == E_PASS1);
	assign last_ph = (ph_q == 3'd4);

	assign coef_addr_a_o = {r_q, k_issue};
	assign coef_addr_b_o = {r_q, k_issue[2:1], 1'b1};

	// T is written row-major in pass 1 and read down column c in pass 2
	assign t_addr_a = pass1 ? {r_q, c_q} : {k_issue, c_q};
	assign t_addr_b = {k_issue[2:1], 1'b1, c_q};

	block_ram #(.DATA_W($bits(tval_t))) t_ram (
		.Clock     (Clock),
		.addr_a_i  (t_addr_a),
		.addr_b_i  (t_addr_b),
		.wdata_a_i (result >>> `PASS1_SHIFT),
		.wdata_b_i ('0),
		.we_a_i    (pass1 && last_ph),
		.we_b_i    (1'b0),
		.rdata_a_o (t_rdata_a),
		.rdata_b_o (t_rdata_b)
	);

	always_comb begin
		if (state_q == E_PASS2) begin
			op_a = t_rdata_a;
			op_b = t_rdata_b;
			cidx_a = {k_data, r_q};
			cidx_b = {k_data[2:1], 1'b1, r_q};
		end else begin
			op_a = tval_t'(coef_data_a_i);
			op_b = tval_t'(coef_data_b_i);
			cidx_a = {k_data, c_q};
			cidx_b = {k_data[2:1], 1'b1, c_q};
		end
	end

	assign prod_sum = op_a * tval_t'(c_table[cidx_a]) + op_b * tval_t'(c_table[cidx_b]);
	assign result = acc_q + prod_sum;
	assign scaled = result >>> `PASS2_SHIFT;

	always_comb begin
		if (scaled < 0) begin
			clip_pix = 8'd0;
		end else if (scaled > 255) begin
			clip_pix = 8'd255;
		end else begin
			clip_pix = scaled[7:0];
		end
	end

	// pass 2 waits in ph 4 while the output register is still full
	assign can_load = !pix_valid_q || pix_ready_i;
	assign advance = (state_q != E_IDLE) && !((state_q == E_PASS2) && last_ph && !can_load);
	assign load_out = (state_q == E_PASS2) && last_ph && can_load;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state_q <= E_IDLE;
			ph_q <= '0;
			r_q <= '0;
			c_q <= '0;
		end else if (state_q == E_IDLE) begin
			if (start_i) begin
				state_q <= E_PASS1;
				ph_q <= '0;
				r_q <= '0;
				c_q <= '0;
			end
		end else if (advance) begin
			if (last_ph) begin
				ph_q <= '0;
				{r_q, c_q} <= {r_q, c_q} + 6'd1;
				if ({r_q, c_q} == 6'd63) begin
					state_q <= pass1 ? E_PASS2 : E_IDLE;
				end
			end else begin
				ph_q <= ph_q + 3'd1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (ph_q == 3'd1) begin
			acc_q <= prod_sum;
		end else if (advance && !last_ph) begin
			acc_q <= result;
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			pix_valid_q <= 1'b0;
		end else if (load_out) begin
			pix_valid_q <= 1'b1;
		end else if (pix_ready_i) begin
			pix_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (load_out) begin
			pix_data_q <= clip_pix;
		end
	end

	assign pix_o = '{valid: pix_valid_q, pixel: pix_data_q};

endmodule

/* design/pixel_writer.sv */
// Pixel pair writer
`include "idct_defines.svh"

module pixel_writer (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  idct_pkg::blk_col_t    blk_col_i,
	input  idct_pkg::blk_row_t    blk_row_i,
	input  idct_pkg::pix_stream_t pix_i,
	output logic                  pix_ready_o,
	output idct_pkg::wb_m2s_t     wb_o,
	input  idct_pkg::wb_s2m_t     wb_i,
	output logic                  block_done_o
);
	import idct_pkg::*;

	writer_state_t state_q;
	logic have_even_q;
	pixel_t even_q;
	sram_data_t word_q;
	logic [4:0] wcnt_q;
	logic done_q;
	logic take;
	logic acked;
	sram_addr_t row_w;
	sram_addr_t col_w;

	assign pix_ready_o = (state_q == W_COLLECT);
	assign take = pix_i.valid && pix_ready_o;
	assign acked = (state_q == W_WRITE) && wb_i.ack;

	// four words per block row
	assign row_w = sram_addr_t'({blk_row_i, wcnt_q[4:2]});
	assign col_w = sram_addr_t'({blk_col_i, wcnt_q[1:0]});

	always_comb begin
		wb_o.cyc = (state_q == W_WRITE);
		wb_o.stb = (state_q == W_WRITE);
		wb_o.we = (state_q == W_WRITE);
		wb_o.adr = row_w * sram_addr_t'(`PIX_STRIDE) + col_w;
		wb_o.dat_w = word_q;
	end

	assign block_done_o = done_q;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state_q <= W_COLLECT;
			have_even_q <= 1'b0;
			wcnt_q <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= acked && (wcnt_q == 5'd31);
			case (state_q)
				W_COLLECT: begin
					if (take) begin
						have_even_q <= !have_even_q;
						if (have_even_q) begin
							state_q <= W_WRITE;
						end
					end
				end
				W_WRITE: begin
					if (wb_i.ack) begin
						wcnt_q <= wcnt_q + 5'd1;
						state_q <= W_COLLECT;
					end
				end
				default: state_q <= W_COLLECT;
			endcase
		end
	end

	// even column lands in the high byte
	always_ff @(posedge Clock) begin
		if (take && !have_even_q) begin
			even_q <= pix_i.pixel;
		end
		if (take && have_even_q) begin
			word_q <= {even_q, pix_i.pixel};
		end
	end

endmodule

/* design/idct_block_top.sv */
// IDCT block engine top
module idct_block_top (
	input  logic               Clock,
	input  logic               Resetn,
	input  logic               start_i,
	input  idct_pkg::blk_col_t blk_col_i,
	input  idct_pkg::blk_row_t blk_row_i,
	input  idct_pkg::wb_s2m_t  wb_i,
	output idct_pkg::wb_m2s_t  wb_o,
	output logic               busy_o,
	output logic               done_o
);
	import idct_pkg::*;

	wb_m2s_t fetch_wb;
	wb_m2s_t writer_wb;
	ram_addr_t fetch_addr;
	ram_addr_t eng_addr_a;
	ram_addr_t eng_addr_b;
	coef_t fetch_data;
	coef_t coef_rdata_a;
	coef_t coef_rdata_b;
	logic fetch_we;
	logic fetch_done;
	logic block_done;
	logic pix_ready;
	pix_stream_t pix;

	block_fetch u_fetch (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.blk_col_i    (blk_col_i),
		.blk_row_i    (blk_row_i),
		.block_done_i (block_done),
		.wb_o         (fetch_wb),
		.wb_i         (wb_i),
		.ram_addr_o   (fetch_addr),
		.ram_data_o   (fetch_data),
		.ram_we_o     (fetch_we),
		.fetch_done_o (fetch_done),
		.busy_o       (busy_o)
	);

	// port a belongs to the fetch while it writes
	block_ram #(.DATA_W($bits(coef_t))) u_coef_ram (
		.Clock     (Clock),
		.addr_a_i  (fetch_we ? fetch_addr : eng_addr_a),
		.addr_b_i  (eng_addr_b),
		.wdata_a_i (fetch_data),
		.wdata_b_i ('0),
		.we_a_i    (fetch_we),
		.we_b_i    (1'b0),
		.rdata_a_o (coef_rdata_a),
		.rdata_b_o (coef_rdata_b)
	);

	idct_matrix_engine u_engine (
		.Clock         (Clock),
		.Resetn        (Resetn),
		.start_i       (fetch_done),
		.coef_addr_a_o (eng_addr_a),
		.coef_addr_b_o (eng_addr_b),
		.coef_data_a_i (coef_rdata_a),
		.coef_data_b_i (coef_rdata_b),
		.pix_o         (pix),
		.pix_ready_i   (pix_ready)
	);

	pixel_writer u_writer (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.blk_col_i    (blk_col_i),
		.blk_row_i    (blk_row_i),
		.pix_i        (pix),
		.pix_ready_o  (pix_ready),
		.wb_o         (writer_wb),
		.wb_i         (wb_i),
		.block_done_o (block_done)
	);

	// fetch and writer never hold the bus together
	assign wb_o = writer_wb.cyc ? writer_wb : fetch_wb;
	assign done_o = block_done;

endmodule

/* verif/idct_chk.sv */
// IDCT bus and control checks
`include "idct_defines.svh"

module idct_chk (
	input logic              Clock,
	input logic              Resetn,
	input idct_pkg::wb_m2s_t wb_o,
	input idct_pkg::wb_s2m_t wb_i,
	input logic              busy_o,
	input logic              done_o
);

	// failed assertions so far
	int fail_cnt = 0;

	stb_needs_cyc: assert property (@(posedge Clock) disable iff (!Resetn)
		wb_o.stb |-> wb_o.cyc)
		else begin
			$error("stb high without cyc");
			fail_cnt++;
		end

	// request held until the slave acks
	bus_held: assert property (@(posedge Clock) disable iff (!Resetn)
		wb_o.stb && !wb_i.ack |=> $stable(wb_o))
		else begin
			$error("bus changed while waiting for ack");
			fail_cnt++;
		end

	done_single: assert property (@(posedge Clock) disable iff (!Resetn)
		done_o |=> !done_o)
		else begin
			$error("done_o longer than one cycle");
			fail_cnt++;
		end

	done_with_busy_fall: assert property (@(posedge Clock) disable iff (!Resetn)
		done_o |-> !busy_o && $past(busy_o))
		else begin
			$error("done_o not aligned with the fall of busy_o");
			fail_cnt++;
		end

	write_in_pixel_region: assert property (@(posedge Clock) disable iff (!Resetn)
		wb_o.we |-> wb_o.adr < `COEF_BASE)
		else begin
			$error("write outside the pixel region");
			fail_cnt++;
		end

endmodule

bind idct_block_top idct_chk u_chk (
	.Clock  (Clock),
	.Resetn (Resetn),
	.wb_o   (wb_o),
	.wb_i   (wb_i),
	.busy_o (busy_o),
	.done_o (done_o)
);

/* verif/idct_tb.sv */
// IDCT block engine testbench
`include "idct_defines.svh"

module idct_tb;
	import idct_pkg::*;

	localparam int CYCLE_LIMIT = 12000;
	localparam int COEF_END = `COEF_BASE + `BLOCK_ROWS * `BLOCK_N * `COEF_STRIDE;

	logic Clock;
	logic Resetn;
	logic start_i;
	blk_col_t blk_col_i;
	blk_row_t blk_row_i;
	wb_s2m_t wb_i;
	wb_m2s_t wb_o;
	logic busy_o;
	logic done_o;

	sram_data_t sram [2**`SRAM_ADDR_W];
	int c_tab [64];
	int coef_blk [64];
	int exp_pix [64];
	sram_addr_t write_log [$];
	integer seed = 32'hd6a3_e2f3;
	int cycle_cnt;
	int done_cnt;
	int bad_reads;
	int err_cnt;
	int test_cnt;
	int failed_tests;
	int wait_left;
	logic pending;

	idct_block_top DUT (
		.Clock     (Clock),
		.Resetn    (Resetn),
		.start_i   (start_i),
		.blk_col_i (blk_col_i),
		.blk_row_i (blk_row_i),
		.wb_i      (wb_i),
		.wb_o      (wb_o),
		.busy_o    (busy_o),
		.done_o    (done_o)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	function automatic int round_real(real v);
		if (v >= 0.0) begin
			return $rtoi(v + 0.5);
		end
		return -$rtoi(0.5 - v);
	endfunction

	// C[u][x] = a(u) cos((2x+1)u pi/16), scaled by 4096
	task automatic build_cos_table();
		real a;
		real pi;
		pi = 3.14159265358979;
		for (int u = 0; u < 8; u++) begin
			a = (u == 0) ? $sqrt(1.0 / 8.0) : $sqrt(2.0 / 8.0);
			for (int x = 0; x < 8; x++) begin
				c_tab[u * 8 + x] = round_real(4096.0 * a * $cos((2 * x + 1) * u * pi / 16.0));
			end
		end
	endtask

	function automatic sram_data_t fill_word(sram_addr_t a);
		return a[15:0] ^ {a[17:16], a[17:16], 12'h3c5};
	endfunction

	function automatic int pix_addr(int col, int row, int w);
		return (row * 8 + w / 4) * `PIX_STRIDE + col * 4 + w % 4;
	endfunction

	task automatic clear_coefs();
		for (int i = 0; i < 64; i++) begin
			coef_blk[i] = 0;
		end
	endtask

	task automatic load_coefs(int col, int row);
		int a;
		for (int i = 0; i < 64; i++) begin
			a = `COEF_BASE + (row * 8 + i / 8) * `COEF_STRIDE + col * 8 + i % 8;
			sram[a] = sram_data_t'(coef_blk[i]);
		end
	endtask

	// two matrix passes in 32-bit arithmetic, then clip
	task automatic model_idct();
		int t [64];
		int acc;
		for (int i = 0; i < 64; i++) begin
			acc = 0;
			for (int k = 0; k < 8; k++) begin
				acc += coef_blk[(i / 8) * 8 + k] * c_tab[k * 8 + i % 8];
			end
			t[i] = acc >>> `PASS1_SHIFT;
		end
		for (int i = 0; i < 64; i++) begin
			acc = 0;
			for (int k = 0; k < 8; k++) begin
				acc += c_tab[k * 8 + i / 8] * t[k * 8 + i % 8];
			end
			acc = acc >>> `PASS2_SHIFT;
			exp_pix[i] = (acc < 0) ? 0 : (acc > 255) ? 255 : acc;
		end
	endtask

	task automatic serve_transfer();
		if (wb_o.we) begin
			sram[wb_o.adr] = wb_o.dat_w;
			write_log.push_back(wb_o.adr);
		end else begin
			if (wb_o.adr < `COEF_BASE || wb_o.adr >= COEF_END) begin
				bad_reads++;
			end
			wb_i.dat_r = sram[wb_o.adr];
		end
		wb_i.ack = 1'b1;
	endtask

	// SRAM slave, ack after 0 to 3 wait cycles
	initial begin
		forever begin
			@(posedge Clock);
			#1;
			if (wb_i.ack) begin
				wb_i.ack = 1'b0;
			end else if (wb_o.cyc && wb_o.stb) begin
				if (!pending) begin
					pending = 1'b1;
					wait_left = $random(seed) & 3;
				end
				if (wait_left == 0) begin
					serve_transfer();
					pending = 1'b0;
				end else begin
					wait_left--;
				end
			end
		end
	end

	always @(negedge Clock) begin
		if (done_o) begin
			done_cnt++;
		end
	end

	always @(posedge Clock) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_equal(string name, int expected, int actual);
		assert (expected == actual) else begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic check_true(bit cond, string what);
		assert (cond) else begin
			$display("Check failed at %0t: %s", $time, what);
			err_cnt++;
		end
	endtask

	// extra_start > 0 pulses start_i again that many cycles into the run
	task automatic run_block(int col, int row, int extra_start);
		int done_before;
		int n;
		write_log.delete();
		done_before = done_cnt;
		@(posedge Clock);
		#1;
		blk_col_i = blk_col_t'(col);
		blk_row_i = blk_row_t'(row);
		start_i = 1'b1;
		n = 0;
		while (done_cnt == done_before) begin
			@(posedge Clock);
			#1;
			// busy and the first read request follow start by one cycle
			if (n == 0) begin
				check_equal("busy_o", 1, busy_o);
				check_equal("wb_o.stb", 1, wb_o.stb);
			end
			start_i = (extra_start > 0) && (n == extra_start);
			n++;
		end
		start_i = 1'b0;
	endtask

	task automatic check_block(int col, int row);
		int a;
		check_equal("write count", 32, write_log.size());
		for (int w = 0; w < 32; w++) begin
			a = pix_addr(col, row, w);
			if (w < write_log.size()) begin
				check_equal("wb_o.adr", a, int'(write_log[w]));
			end
			check_equal($sformatf("sram[%0d]", a), exp_pix[2 * w] * 256 + exp_pix[2 * w + 1],
				int'(sram[a]));
		end
	endtask

	task automatic finish_test(string name, int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: FAILED, %0d errors", name, err_cnt - errs_before);
		end
	endtask

	task automatic idle_after_reset();
		int errs;
		errs = err_cnt;
		repeat (10) begin
			@(negedge Clock);
			check_equal("wb_o.cyc", 0, wb_o.cyc);
			check_equal("wb_o.stb", 0, wb_o.stb);
			check_equal("busy_o", 0, busy_o);
			check_equal("done_o", 0, done_o);
		end
		finish_test("idle after reset", errs);
	endtask

	task automatic dc_only_block();
		int errs;
		int a;
		errs = err_cnt;
		clear_coefs();
		coef_blk[0] = 1000;
		load_coefs(0, 0);
		model_idct();
		run_block(0, 0, 0);
		check_block(0, 0);
		// ring of words just right of and below the block
		for (int r = 0; r < 9; r++) begin
			for (int q = 0; q < 5; q++) begin
				a = r * `PIX_STRIDE + q;
				if (r == 8 || q == 4) begin
					check_equal($sformatf("sram[%0d]", a), fill_word(sram_addr_t'(a)), sram[a]);
				end
			end
		end
		finish_test("dc only block", errs);
	endtask

	task automatic random_block();
		int errs;
		errs = err_cnt;
		for (int i = 0; i < 64; i++) begin
			coef_blk[i] = $random(seed) % 128;
		end
		coef_blk[0] = 640 + $random(seed) % 256;
		load_coefs(17, 11);
		model_idct();
		run_block(17, 11, 0);
		check_block(17, 11);
		finish_test("random block", errs);
	endtask

	task automatic clip_extremes();
		int errs;
		errs = err_cnt;
		clear_coefs();
		coef_blk[0] = 32767;
		load_coefs(5, 3);
		for (int i = 0; i < 64; i++) begin
			exp_pix[i] = 255;
		end
		run_block(5, 3, 0);
		check_block(5, 3);
		coef_blk[0] = -32768;
		load_coefs(5, 3);
		for (int i = 0; i < 64; i++) begin
			exp_pix[i] = 0;
		end
		run_block(5, 3, 0);
		check_block(5, 3);
		finish_test("clip extremes", errs);
	endtask

	task automatic edge_block_restart();
		int errs;
		int done_before;
		errs = err_cnt;
		done_before = done_cnt;
		for (int i = 0; i < 64; i++) begin
			coef_blk[i] = $random(seed) % 64;
		end
		coef_blk[0] = 500;
		load_coefs(39, 29);
		model_idct();
		run_block(39, 29, 10);
		repeat (40) @(posedge Clock);
		check_equal("done_o pulses", 1, done_cnt - done_before);
		check_block(39, 29);
		check_equal("busy_o", 0, busy_o);
		check_true(bad_reads == 0, "a read left the coefficient region");
		finish_test("edge block with restart", errs);
	endtask

	initial begin
		Resetn = 1'b0;
		start_i = 1'b0;
		blk_col_i = '0;
		blk_row_i = '0;
		wb_i = '0;
		pending = 1'b0;
		build_cos_table();
		for (int a = 0; a < 2**`SRAM_ADDR_W; a++) begin
			sram[a] = fill_word(sram_addr_t'(a));
		end
		repeat (5) @(posedge Clock);
		#1;
		Resetn = 1'b1;
		idle_after_reset();
		dc_only_block();
		random_block();
		clip_extremes();
		edge_block_restart();
		$display("tests: %0d, failed: %0d, errors: %0d, bus check failures: %0d",
			test_cnt, failed_tests, err_cnt, DUT.u_chk.fail_cnt);
		if (failed_tests == 0 && DUT.u_chk.fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+design
design/idct_pkg.sv
design/block_ram.sv
design/block_fetch.sv
design/idct_matrix_engine.sv
design/pixel_writer.sv
design/idct_block_top.sv
verif/idct_chk.sv
verif/idct_tb.sv

/* Makefile */
# Verilator build and run of the IDCT block testbench

VERILATOR ?= verilator
TOP       ?= idct_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
FAIL_MSG  ?= Some tests failed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
